/* hw/cachePkg.sv */
`default_nettype none

package cachePkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Data and address width
    localparam int wordW = 32;

    // Bytes per word and the byte-offset field below the word index
    localparam int bytesPerWord = wordW / 8;
    localparam int byteOffW = $clog2(bytesPerWord);

    // One data or address word
    typedef logic [wordW-1:0] word_t;

    // Byte enables for a store, bit 0 is the low byte
    typedef logic [bytesPerWord-1:0] mask_t;

    // ----------------------------------------
    // States
    // ----------------------------------------

    // Miss handling sequence of a cache
    typedef enum logic [1:0] {
        Idle,
        WriteBack,
        Fetch,
        Update
    } ctrlState_t;

    // Current owner of the external bus
    typedef enum logic [1:0] {
        ArbIdle,
        ArbData,
        ArbInstr
    } arbState_t;

endpackage

`default_nettype wire

/* hw/cacheBusIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface cacheBusIf;
    import cachePkg::*;

    // Request levels, held until ready
    logic busRead;
    logic busWrite;

    // Word address and write data of the current beat
    word_t addr;
    word_t wData;

    // Read data, valid with ready
    word_t rData;

    // One pulse per completed word
    logic ready;

    // Cache side
    modport cache (
        output busRead, busWrite, addr, wData,
        input  rData, ready
    );

    // Arbiter side
    modport arbiter (
        input  busRead, busWrite, addr, wData,
        output rData, ready
    );

endinterface

`default_nettype wire

/* hw/cacheWay.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheWay #(
    parameter int blockWords = 4,
    parameter int sets = 4,
    localparam int setW = $clog2(sets),
    localparam int offW = $clog2(blockWords),
    localparam int tagW = cachePkg::wordW - setW - offW - cachePkg::byteOffW
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [setW-1:0]    set,
    input  logic [offW-1:0]    wordSel,
    input  logic [tagW-1:0]    tagIn,
    input  cachePkg::word_t    wordIn,
    input  cachePkg::mask_t    mask,
    input  logic               storeEn,
    input  logic               refillEn,
    input  logic               markValid,
    output logic               valid,
    output logic               dirty,
    output logic [tagW-1:0]    tag,
    output cachePkg::word_t    wordOut
);
    import cachePkg::*;

    // Block data and tags, one entry per set
    word_t           blockMem [sets][blockWords];
    logic [tagW-1:0] tagMem [sets];

    // Line status
    logic [sets-1:0] validBits;
    logic [sets-1:0] dirtyBits;

    // Refill beats write whole words, stores only the enabled bytes
    always_ff @(posedge clk) begin
        if (refillEn) begin
            blockMem[set][wordSel] <= wordIn;
        end else if (storeEn) begin
            for (int b = 0; b < bytesPerWord; b++) begin
                if (mask[b]) begin
                    blockMem[set][wordSel][8*b +: 8] <= wordIn[8*b +: 8];
                end
            end
        end
        // Tag is taken with the last refill word
        if (refillEn && markValid) begin
            tagMem[set] <= tagIn;
        end
    end

    // Completed refill leaves a clean valid line
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            validBits <= '0;
            dirtyBits <= '0;
        end else if (refillEn && markValid) begin
            validBits[set] <= 1'b1;
            dirtyBits[set] <= 1'b0;
        end else if (storeEn) begin
            dirtyBits[set] <= 1'b1;
        end
    end

    // Read side of the addressed set
    assign valid   = validBits[set];
    assign dirty   = dirtyBits[set];
    assign tag     = tagMem[set];
    assign wordOut = blockMem[set][wordSel];

endmodule

`default_nettype wire

/* hw/cacheController.sv */
`timescale 1ns/10ps
`default_nettype none

module cacheController #(
    parameter int blockWords = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 access,
    input  logic                 hit,
    input  logic                 victimDirty,
    input  logic                 lastWord,
    input  logic                 ready,
    output cachePkg::ctrlState_t state,
    output logic                 stall,
    output logic                 busRead,
    output logic                 busWrite,
    output logic                 refillEn,
    output logic                 counterClear
);
    import cachePkg::*;

    // A one-word block ends its burst on the first beat
    localparam bit singleWord = (blockWords == 1);

    ctrlState_t nextState;
    logic       burstDone;
    logic       miss;

    assign miss      = access & ~hit;
    assign burstDone = ready & (lastWord | singleWord);

    // ----------------------------------------
    // State register
    // ----------------------------------------
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= Idle;
        end else begin
            state <= nextState;
        end
    end

    // Write-back only for a dirty victim
    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (miss) begin
                    nextState = victimDirty ? WriteBack : Fetch;
                end
            end
            WriteBack: begin
                if (burstDone) begin
                    nextState = Fetch;
                end
            end
            Fetch: begin
                if (burstDone) begin
                    nextState = Update;
                end
            end
            default: nextState = Idle;
        endcase
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------

    // In Update the new line hits, so stall drops there
    assign stall = (state == WriteBack) | (state == Fetch) | miss;

    // Bus levels follow the burst states
    assign busWrite = (state == WriteBack);
    assign busRead  = (state == Fetch);

    // Each refill beat lands in the victim way
    assign refillEn = (state == Fetch) & ready;

    // Word counter starts every miss at zero
    assign counterClear = (state == Idle) | (state == Update);

endmodule

`default_nettype wire

/* hw/dataCache.sv */
`timescale 1ns/10ps
`default_nettype none

module dataCache #(
    parameter int blockWords = 4,
    parameter int sets = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  cachePkg::word_t addr,
    input  cachePkg::word_t wData,
    input  cachePkg::mask_t mask,
    input  logic            read,
    input  logic            write,
    output cachePkg::word_t rData,
    output logic            stall,
    cacheBusIf.cache        bus
);
    import cachePkg::*;

    localparam int setW = $clog2(sets);
    localparam int offW = $clog2(blockWords);
    localparam int tagW = wordW - setW - offW - byteOffW;

    // Request address fields
    logic [tagW-1:0] reqTag;
    logic [setW-1:0] setIdx;
    logic [offW-1:0] reqWord;

    // Per-way status and read data
    logic [1:0]      wValid;
    logic [1:0]      wDirty;
    logic [1:0]      hitW;
    logic [tagW-1:0] wTag [2];
    word_t           wWord [2];

    // Control
    ctrlState_t      state;
    logic            access;
    logic            hit;
    logic            refillEn;
    logic            counterClear;
    logic            lastWord;
    logic            busy;
    logic [offW-1:0] counter;
    logic [offW-1:0] wordSel;
    word_t           wayIn;

    // Victim choice and LRU, bit set means way 1 was used last
    logic            victimNow;
    logic            victimReg;
    logic            victim;
    logic [sets-1:0] lru;

    assign reqTag  = addr[wordW-1 -: tagW];
    assign setIdx  = addr[byteOffW+offW +: setW];
    assign reqWord = addr[byteOffW +: offW];
    assign access  = read | write;
    assign busy    = (state == WriteBack) | (state == Fetch);

    // ----------------------------------------
    // Ways
    // ----------------------------------------

    // Bursts walk the block with the counter
    assign wordSel = busy ? counter : reqWord;
    assign wayIn   = (state == Fetch) ? bus.rData : wData;

    for (genvar i = 0; i < 2; i++) begin : g_way
        cacheWay #(
            .blockWords(blockWords),
            .sets(sets)
        ) way (
            .clk(clk),
            .reset(reset),
            .set(setIdx),
            .wordSel(wordSel),
            .tagIn(reqTag),
            .wordIn(wayIn),
            .mask(mask),
            .storeEn(write & hitW[i] & ~stall),
            .refillEn(refillEn & (victim == 1'(i))),
            .markValid(lastWord),
            .valid(wValid[i]),
            .dirty(wDirty[i]),
            .tag(wTag[i]),
            .wordOut(wWord[i])
        );
        assign hitW[i] = wValid[i] & (wTag[i] == reqTag);
    end

    assign hit   = |hitW;
    assign rData = hitW[1] ? wWord[1] : wWord[0];

    // ----------------------------------------
    // Victim and LRU
    // ----------------------------------------

    // Invalid way first, else the one not used last
    always_comb begin
        if (!wValid[0]) begin
            victimNow = 1'b0;
        end else if (!wValid[1]) begin
            victimNow = 1'b1;
        end else begin
            victimNow = ~lru[setIdx];
        end
    end

    // Frozen for the whole miss, since refill beats move the LRU bit
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            victimReg <= 1'b0;
        end else if (state == Idle) begin
            victimReg <= victimNow;
        end
    end

    assign victim = (state == Idle) ? victimNow : victimReg;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            lru <= '0;
        end else if (access & hit & ~stall) begin
            lru[setIdx] <= hitW[1];
        end else if (refillEn) begin
            lru[setIdx] <= victim;
        end
    end

    // ----------------------------------------
    // Word counter and bus side
    // ----------------------------------------
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            counter <= '0;
        end else if (counterClear) begin
            counter <= '0;
        end else if (bus.ready) begin
            counter <= counter + 1'b1;
        end
    end

    assign lastWord = (counter == offW'(blockWords - 1));

    // Write-back goes to the victim's block, refill to the request's
    assign bus.addr = (state == WriteBack) ?
        {wTag[victim], setIdx, counter, {byteOffW{1'b0}}} :
        {reqTag, setIdx, counter, {byteOffW{1'b0}}};
    assign bus.wData = wWord[victim];

    cacheController #(
        .blockWords(blockWords)
    ) ctrl (
        .clk(clk),
        .reset(reset),
        .access(access),
        .hit(hit),
        .victimDirty(wValid[victim] & wDirty[victim]),
        .lastWord(lastWord),
        .ready(bus.ready),
        .state(state),
        .stall(stall),
        .busRead(bus.busRead),
        .busWrite(bus.busWrite),
        .refillEn(refillEn),
        .counterClear(counterClear)
    );

endmodule

`default_nettype wire

/* hw/instrCache.sv */
`timescale 1ns/10ps
`default_nettype none

module instrCache #(
    parameter int blockWords = 4,
    parameter int sets = 8
) (
    input  logic            clk,
    input  logic            reset,
    input  cachePkg::word_t addr,
    input  logic            fetch,
    output cachePkg::word_t rData,
    output logic            stall,
    cacheBusIf.cache        bus
);
    import cachePkg::*;

    localparam int setW = $clog2(sets);
    localparam int offW = $clog2(blockWords);
    localparam int tagW = wordW - setW - offW - byteOffW;

    logic [tagW-1:0] reqTag;
    logic [setW-1:0] setIdx;
    logic [offW-1:0] reqWord;
    logic [tagW-1:0] lineTag;
    logic [offW-1:0] counter;
    logic            lineValid;
    logic            hit;
    logic            lastWord;
    ctrlState_t      state;

    assign reqTag   = addr[wordW-1 -: tagW];
    assign setIdx   = addr[byteOffW+offW +: setW];
    assign reqWord  = addr[byteOffW +: offW];
    assign hit      = lineValid & (lineTag == reqTag);
    assign lastWord = (counter == offW'(blockWords - 1));

    // Idle, Fetch, Update only
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= Idle;
        end else begin
            case (state)
                Idle:    if (fetch & ~hit) state <= Fetch;
                Fetch:   if (bus.ready & lastWord) state <= Update;
                default: state <= Idle;
            endcase
        end
    end

    // Counter runs only during the refill burst
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            counter <= '0;
        end else if (state != Fetch) begin
            counter <= '0;
        end else if (bus.ready) begin
            counter <= counter + 1'b1;
        end
    end

    // Read-only way, never dirty
    cacheWay #(
        .blockWords(blockWords),
        .sets(sets)
    ) way (
        .clk(clk),
        .reset(reset),
        .set(setIdx),
        .wordSel((state == Fetch) ? counter : reqWord),
        .tagIn(reqTag),
        .wordIn(bus.rData),
        .mask('0),
        .storeEn(1'b0),
        .refillEn((state == Fetch) & bus.ready),
        .markValid(lastWord),
        .valid(lineValid),
        .dirty(),
        .tag(lineTag),
        .wordOut(rData)
    );

    assign stall = (state == Fetch) | (fetch & ~hit);

    // Read bursts only
    assign bus.busRead  = (state == Fetch);
    assign bus.busWrite = 1'b0;
    assign bus.addr     = {reqTag, setIdx, counter, {byteOffW{1'b0}}};
    assign bus.wData    = '0;

endmodule

`default_nettype wire

/* hw/busArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module busArbiter #(
    parameter int blockWords = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  cachePkg::word_t hRData,
    input  logic            hReady,
    output cachePkg::word_t hAddr,
    output cachePkg::word_t hWData,
    output logic            hRead,
    output logic            hWrite,
    cacheBusIf.arbiter      dPort,
    cacheBusIf.arbiter      iPort
);
    import cachePkg::*;

    localparam int offW = $clog2(blockWords);

    arbState_t       state;
    arbState_t       grant;
    logic            dReq;
    logic            iReq;
    logic            midBurst;
    logic [offW-1:0] burstCount;

    assign dReq     = dPort.busRead | dPort.busWrite;
    assign iReq     = iPort.busRead | iPort.busWrite;
    assign midBurst = (burstCount != '0);

    // Idle bus goes to the data cache first
    // Owner keeps it while its levels stay up or a burst is open
    always_comb begin
        case (state)
            ArbData:  grant = (dReq | midBurst) ? ArbData : ArbIdle;
            ArbInstr: grant = (iReq | midBurst) ? ArbInstr : ArbIdle;
            default:  grant = dReq ? ArbData : (iReq ? ArbInstr : ArbIdle);
        endcase
    end

    // Owner and beat count within the current burst
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state      <= ArbIdle;
            burstCount <= '0;
        end else begin
            state <= grant;
            if (hReady && grant != ArbIdle) begin
                burstCount <= burstCount + 1'b1;
            end
        end
    end

    // Owner's request to the external bus
    always_comb begin
        hRead  = 1'b0;
        hWrite = 1'b0;
        hAddr  = dPort.addr;
        hWData = dPort.wData;
        if (grant == ArbData) begin
            hRead  = dPort.busRead;
            hWrite = dPort.busWrite;
        end else if (grant == ArbInstr) begin
            hRead  = iPort.busRead;
            hWrite = iPort.busWrite;
            hAddr  = iPort.addr;
            hWData = iPort.wData;
        end
    end

    // Ready reaches the owner only
    assign dPort.rData = hRData;
    assign iPort.rData = hRData;
    assign dPort.ready = hReady & (grant == ArbData);
    assign iPort.ready = hReady & (grant == ArbInstr);

endmodule

`default_nettype wire

/* hw/memSubsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module memSubsystem #(
    parameter int blockWords = 4,
    parameter int dataSets = 4,
    parameter int instrSets = 8
) (
    input  logic            clk,
    input  logic            reset,
    // Data port
    input  cachePkg::word_t dAddr,
    input  cachePkg::word_t dWData,
    input  cachePkg::mask_t dMask,
    input  logic            dRead,
    input  logic            dWrite,
    output cachePkg::word_t dRData,
    output logic            dStall,
    // Instruction port
    input  cachePkg::word_t iAddr,
    input  logic            iFetch,
    output cachePkg::word_t iRData,
    output logic            iStall,
    // External bus
    output cachePkg::word_t hAddr,
    output cachePkg::word_t hWData,
    output logic            hRead,
    output logic            hWrite,
    input  cachePkg::word_t hRData,
    input  logic            hReady
);

    // One path per cache into the arbiter
    cacheBusIf dBus ();
    cacheBusIf iBus ();

    dataCache #(
        .blockWords(blockWords),
        .sets(dataSets)
    ) dCache (
        .clk(clk),
        .reset(reset),
        .addr(dAddr),
        .wData(dWData),
        .mask(dMask),
        .read(dRead),
        .write(dWrite),
        .rData(dRData),
        .stall(dStall),
        .bus(dBus)
    );

    instrCache #(
        .blockWords(blockWords),
        .sets(instrSets)
    ) iCache (
        .clk(clk),
        .reset(reset),
        .addr(iAddr),
        .fetch(iFetch),
        .rData(iRData),
        .stall(iStall),
        .bus(iBus)
    );

    busArbiter #(
        .blockWords(blockWords)
    ) arbiter (
        .clk(clk),
        .reset(reset),
        .hRData(hRData),
        .hReady(hReady),
        .hAddr(hAddr),
        .hWData(hWData),
        .hRead(hRead),
        .hWrite(hWrite),
        .dPort(dBus),
        .iPort(iBus)
    );

endmodule

`default_nettype wire

/* verif/memSubsystem_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module memSubsystemChk #(
    parameter int blockWords = 4
) (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               hRead,
    input wire logic               hWrite,
    input wire logic               hReady,
    input wire cachePkg::word_t    hAddr,
    input wire logic               dStall,
    input wire logic               iStall,
    input wire cachePkg::arbState_t arbState
);

    localparam int offW = $clog2(blockWords);

    // Count of failed assertions
    int failCount = 0;

    // Completed beats on the external bus, modulo the burst length
    logic [offW-1:0] beatCount;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            beatCount <= '0;
        end else if ((hRead || hWrite) && hReady) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    // ----------------------------------------
    // Bus protocol
    // ----------------------------------------

    // Read and write never share a beat
    assert property (@(posedge clk) disable iff (reset) !(hRead && hWrite))
        else begin failCount++; $error("hRead and hWrite high together"); end

    // Address held while the beat waits for ready
    assert property (@(posedge clk) disable iff (reset)
        (hRead || hWrite) && !hReady |=> $stable(hAddr))
        else begin failCount++; $error("hAddr moved before ready"); end

    // ----------------------------------------
    // Ownership and stalls
    // ----------------------------------------

    // A started burst keeps its owner up to the last beat
    assert property (@(posedge clk) disable iff (reset)
        beatCount != '0 |=> $stable(arbState))
        else begin failCount++; $error("owner changed in mid-burst"); end

    // Both caches idle right after reset
    assert property (@(posedge clk) $fell(reset) |-> !dStall && !iStall)
        else begin failCount++; $error("stall high in first cycle after reset"); end

endmodule

bind memSubsystem memSubsystemChk #(
    .blockWords(blockWords)
) chk (
    .clk(clk),
    .reset(reset),
    .hRead(hRead),
    .hWrite(hWrite),
    .hReady(hReady),
    .hAddr(hAddr),
    .dStall(dStall),
    .iStall(iStall),
    .arbState(arbiter.state)
);

`default_nettype wire

/* verif/memSubsystemTb.sv */
`timescale 1ns/10ps
`default_nettype none

module memSubsystemTb;
    import cachePkg::*;

    localparam int blockWords = 4;
    localparam int memWords = 1024;
    localparam word_t fillKey = 32'h5a3c_0000;
    // Ready comes 1 to 4 cycles after the request, plus one gap cycle
    localparam int maxBeat = 6;
    localparam int numAccesses = 40;
    localparam int missCycles = 2 * 2 * blockWords * maxBeat + 10;
    // In ns, 100 ns per clock cycle
    localparam time watchdogLimit = numAccesses * missCycles * 100 + 20000;

    logic clk;
    logic reset;
    word_t dAddr, dWData, dRData, iAddr, iRData;
    word_t hAddr, hWData, hRData;
    mask_t dMask;
    logic dRead, dWrite, dStall, iFetch, iStall;
    logic hRead, hWrite, hReady;

    // Bus memory and the expected contents
    word_t memArr [memWords];
    word_t refArr [memWords];
    integer seed = 32'h0399d4dc;
    int waitCnt;

    memSubsystem #(.blockWords(blockWords), .dataSets(4), .instrSets(8)) i_dut (.*);

    assign hRData = memArr[hAddr[11:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic reportMismatch(input string name, input word_t expVal, input word_t actVal);
        abortRun($sformatf("[FAIL] %s expected %h actual %h", name, expVal, actVal));
    endtask

    // Bound checker failures end the run at once
    always @(negedge clk) begin
        if (i_dut.chk.failCount != 0) begin
            abortRun("Bus checker assertion failed");
        end
    end

    // Memory model, one ready pulse per beat after a random wait
    initial begin
        for (int i = 0; i < memWords; i++) begin
            memArr[i] = word_t'(i * 4) ^ fillKey;
            refArr[i] = memArr[i];
        end
        hReady = 1'b0;
        waitCnt = $random(seed) & 3;
        forever begin
            @(posedge clk);
            if (hWrite && hReady) begin
                memArr[hAddr[11:2]] <= hWData;
            end
            hReady <= 1'b0;
            if (!hReady && (hRead || hWrite)) begin
                if (waitCnt == 0) begin
                    hReady <= 1'b1;
                    waitCnt = $random(seed) & 3;
                end else begin
                    waitCnt = waitCnt - 1;
                end
            end
        end
    end

    // hitMode 1 demands a hit and 2 a miss
    task automatic dataAccess(input string name, input word_t addr, input logic isWrite,
                              input word_t wd, input mask_t m, input int hitMode);
        word_t expVal;
        @(posedge clk);
        dAddr <= addr;
        dWData <= wd;
        dMask <= m;
        dRead <= !isWrite;
        dWrite <= isWrite;
        @(negedge clk);
        assert (hitMode != 1 || !dStall) else abortRun({name, ": dStall rose on a hit"});
        assert (hitMode != 2 || dStall) else abortRun({name, ": no stall on a miss"});
        while (dStall) @(negedge clk);
        if (isWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (m[b]) refArr[addr[11:2]][8*b +: 8] = wd[8*b +: 8];
            end
        end else begin
            expVal = refArr[addr[11:2]];
            assert (dRData === expVal) else reportMismatch(name, expVal, dRData);
        end
        @(posedge clk);
        dRead <= 1'b0;
        dWrite <= 1'b0;
    endtask

    task automatic fetchAccess(input string name, input word_t addr, input int hitMode);
        word_t expVal;
        @(posedge clk);
        iAddr <= addr;
        iFetch <= 1'b1;
        @(negedge clk);
        assert (hitMode != 1 || !iStall) else abortRun({name, ": iStall rose on a hit"});
        assert (hitMode != 2 || iStall) else abortRun({name, ": no stall on a miss"});
        while (iStall) @(negedge clk);
        expVal = refArr[addr[11:2]];
        assert (iRData === expVal) else reportMismatch(name, expVal, iRData);
        @(posedge clk);
        iFetch <= 1'b0;
    endtask

    initial begin
        #(watchdogLimit);
        abortRun("Watchdog expired before the tests finished");
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        reset = 1'b1;
        dAddr = '0;
        dWData = '0;
        dMask = '0;
        dRead = 1'b0;
        dWrite = 1'b0;
        iAddr = '0;
        iFetch = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Cold misses, then hits
        dataAccess("coldRead", 32'h150, 0, '0, '0, 2);
        dataAccess("coldReadHit", 32'h154, 0, '0, '0, 1);
        dataAccess("coldReadAgain", 32'h150, 0, '0, '0, 1);
        // Masked store merge
        dataAccess("maskedStore", 32'h154, 1, 32'haabbccdd, 4'b0101, 1);
        dataAccess("maskedRead", 32'h154, 0, '0, '0, 1);
        // Three blocks into set 2, dirty one evicted
        dataAccess("dirtyStore", 32'h024, 1, 32'h12345678, 4'b1111, 2);
        dataAccess("evictFill", 32'h060, 0, '0, '0, 2);
        dataAccess("evictMiss", 32'h0a0, 0, '0, '0, 2);
        dataAccess("evictReload", 32'h024, 0, '0, '0, 2);
        // LRU order in set 3
        dataAccess("lruFirst", 32'h030, 0, '0, '0, 2);
        dataAccess("lruSecond", 32'h070, 0, '0, '0, 2);
        dataAccess("lruTouch", 32'h034, 0, '0, '0, 1);
        dataAccess("lruNew", 32'h0b0, 0, '0, '0, 2);
        dataAccess("lruKept", 32'h030, 0, '0, '0, 1);
        dataAccess("lruEvicted", 32'h070, 0, '0, '0, 2);
        // Instruction fetches, same set replaces
        fetchAccess("fetchCold", 32'h400, 2);
        fetchAccess("fetchHit", 32'h404, 1);
        fetchAccess("fetchConflict", 32'h480, 2);
        fetchAccess("fetchReplaced", 32'h40c, 2);
        // Both caches miss in the same cycle
        for (int i = 0; i < 4; i++) begin
            fork
                dataAccess("concurrentData", 32'h200 + i * 32'h44, 0, '0, '0, 2);
                fetchAccess("concurrentFetch", 32'h600 + i * 32'h84, 2);
            join
        end

        repeat (2) @(posedge clk);
        if (i_dut.chk.failCount == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Bus checker assertions failed");
            $display("Something failed");
            $fatal(1, "run stopped");
        end
    end

endmodule

`default_nettype wire

/* project.f */
hw/cachePkg.sv
hw/cacheBusIf.sv
hw/cacheWay.sv
hw/cacheController.sv
hw/dataCache.sv
hw/instrCache.sv
hw/busArbiter.sv
hw/memSubsystem.sv
verif/memSubsystem_chk.sv
verif/memSubsystemTb.sv

/* Makefile */
# Verilator build and run for the cache memory subsystem

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "RESULT: pass" || (echo "RESULT: fail"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
